// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_fir_top
FILELIST = src.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: fir_assertions.sv
`default_nettype none

module fir_assertions (
   input wire logic wb_clk_i,
   input wire logic wb_rst_i,
   input wire logic feed_last_i,
   input wire logic busy_o,
   input wire logic feed_en_o,
   input wire logic done_pulse_o
);
   timeunit 1ns;
   timeprecision 100ps;

   done_one_cycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      done_pulse_o |=> !done_pulse_o)
      else $error("done pulse held for more than one cycle");

   // feed runs to the last index and never ends a block
   feed_only_busy: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      feed_en_o |=> busy_o && (feed_en_o || $past(feed_last_i)))
      else $error("feed enable dropped early or outside a busy block");

   // busy may only drop right after the done pulse
   busy_ends_with_done: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      busy_o && !done_pulse_o |=> busy_o)
      else $error("busy fell without a done pulse");

endmodule

bind fir_seq_fsm fir_assertions u_fir_assertions (.*);

`default_nettype wire

// File: fir_buf_if.sv
`include "fir_config.svh"
`default_nettype none

interface fir_buf_if #(
   parameter type payload_t = logic [15:0]
);

   logic                   wr_en;
   logic [`FIR_ADDR_W-1:0] wr_addr;
   payload_t               wr_data;
   logic [`FIR_ADDR_W-1:0] rd_addr;
   payload_t               rd_data;

   modport writer (output wr_en, wr_addr, wr_data);
   modport reader (output rd_addr, input rd_data);
   modport mem    (input wr_en, wr_addr, wr_data, rd_addr, output rd_data);

endinterface

`default_nettype wire

// File: fir_bus_pkg.sv
`default_nettype none

package fir_bus_pkg;

   typedef logic [31:0] wb_data_t;

   // word index, wb_adr_i[5:2]
   typedef enum logic [3:0] {
      REG_CTRL    = 4'd0,
      REG_WR_ADDR = 4'd1,
      REG_WR_DATA = 4'd2,
      REG_RD_ADDR = 4'd3,
      REG_STATUS  = 4'd4,
      REG_RD_DATA = 4'd5
   } reg_idx_e;

   // bit positions
   localparam int CTRL_START_BIT  = 0;
   localparam int CTRL_IRQ_EN_BIT = 1;
   localparam int STAT_BUSY_BIT   = 0;
   localparam int STAT_DONE_BIT   = 1;

endpackage

`default_nettype wire

// File: fir_config.svh
`ifndef FIR_CONFIG_SVH
`define FIR_CONFIG_SVH

// samples per block
`define FIR_BUF_DEPTH 32

// buffer index width, must cover FIR_BUF_DEPTH
`define FIR_ADDR_W 5

// filter length
`define FIR_TAPS 8

`endif

// File: fir_dsp_pkg.sv
`include "fir_config.svh"
`default_nettype none

package fir_dsp_pkg;

   typedef logic signed [15:0] sample_t;
   typedef logic signed [15:0] coef_t;
   typedef logic signed [31:0] acc_t;

   // symmetric low-pass taps
   localparam coef_t FIR_COEFS [`FIR_TAPS] = '{
      16'sd3, -16'sd5, 16'sd12, 16'sd40,
      16'sd40, 16'sd12, -16'sd5, 16'sd3
   };

endpackage

`default_nettype wire

// File: fir_filter.sv
`include "fir_config.svh"
`default_nettype none

module fir_filter (
   input  wire logic                 wb_clk_i,
   input  wire logic                 wb_rst_i,
   input  wire logic                 clr_i,
   input  wire logic                 in_valid_i,
   input  wire fir_dsp_pkg::sample_t in_sample_i,
   output logic                      out_valid_o,
   output fir_dsp_pkg::acc_t         out_acc_o
);

   // dly_q[0] holds x[n-1]
   fir_dsp_pkg::sample_t dly_q [`FIR_TAPS-1];
   fir_dsp_pkg::acc_t    sum_d;

   always_comb begin
      sum_d = fir_dsp_pkg::acc_t'(in_sample_i) *
              fir_dsp_pkg::acc_t'(fir_dsp_pkg::FIR_COEFS[0]);
      for (int k = 1; k < `FIR_TAPS; k++) begin
         sum_d = sum_d + fir_dsp_pkg::acc_t'(dly_q[k-1]) *
                         fir_dsp_pkg::acc_t'(fir_dsp_pkg::FIR_COEFS[k]);
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (clr_i) begin
         for (int k = 0; k < `FIR_TAPS - 1; k++) begin
            dly_q[k] <= '0;
         end
      end else if (in_valid_i) begin
         dly_q[0] <= in_sample_i;
         for (int k = 1; k < `FIR_TAPS - 1; k++) begin
            dly_q[k] <= dly_q[k-1];
         end
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         out_valid_o <= 1'b0;
      end else begin
         out_valid_o <= in_valid_i;
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (in_valid_i) begin
         out_acc_o <= sum_d;
      end
   end

endmodule

`default_nettype wire

// File: fir_sample_buffer.sv
`include "fir_config.svh"
`default_nettype none

module fir_sample_buffer #(
   parameter type payload_t = logic [15:0]
) (
   input  wire logic wb_clk_i,
   fir_buf_if.mem    bus
);

   payload_t mem_q [`FIR_BUF_DEPTH];

   always_ff @(posedge wb_clk_i) begin
      if (bus.wr_en) begin
         mem_q[bus.wr_addr] <= bus.wr_data;
      end
   end

   // asynchronous read port
   assign bus.rd_data = mem_q[bus.rd_addr];

endmodule

`default_nettype wire

// File: fir_sample_counter.sv
`include "fir_config.svh"
`default_nettype none

module fir_sample_counter (
   input  wire logic             wb_clk_i,
   input  wire logic             wb_rst_i,
   input  wire logic             clr_i,
   input  wire logic             en_i,
   output logic [`FIR_ADDR_W-1:0] idx_o,
   output logic                  last_o
);

   localparam logic [`FIR_ADDR_W-1:0] LAST_IDX = `FIR_ADDR_W'(`FIR_BUF_DEPTH - 1);

   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i || clr_i) begin
         idx_o <= '0;
      end else if (en_i) begin
         // wraps past the last index
         idx_o <= idx_o + `FIR_ADDR_W'(1);
      end
   end

   assign last_o = idx_o == LAST_IDX;

endmodule

`default_nettype wire

// File: fir_seq_fsm.sv
`default_nettype none

module fir_seq_fsm (
   input  wire logic wb_clk_i,
   input  wire logic wb_rst_i,
   input  wire logic start_i,
   input  wire logic feed_last_i,
   input  wire logic store_last_i,
   input  wire logic out_valid_i,
   output logic      busy_o,
   output logic      clr_o,
   output logic      feed_en_o,
   output logic      store_clr_o,
   output logic      done_pulse_o
);

   typedef enum logic [1:0] {
      IDLE,
      FEED,
      DRAIN
   } state_e;

   state_e state_q;
   state_e state_d;

   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE:    if (start_i) state_d = FEED;
         FEED:    if (feed_last_i) state_d = DRAIN;
         // last result leaves the filter one cycle after the last sample
         DRAIN:   if (store_last_i && out_valid_i) state_d = IDLE;
         default: state_d = IDLE;
      endcase
   end

   assign busy_o       = state_q != IDLE;
   assign clr_o        = state_q == IDLE && start_i;
   assign store_clr_o  = clr_o;
   assign feed_en_o    = state_q == FEED;
   assign done_pulse_o = state_q == DRAIN && store_last_i && out_valid_i;

endmodule

`default_nettype wire

// File: fir_top.sv
`include "fir_config.svh"
`default_nettype none

module fir_top (
   input  wire logic        wb_clk_i,
   input  wire logic        wb_rst_i,
   input  wire logic [31:0] wb_adr_i,
   input  wire logic [31:0] wb_dat_i,
   // full-word accesses only, byte lanes not decoded
   input  wire logic [3:0]  wb_sel_i,
   input  wire logic        wb_we_i,
   input  wire logic        wb_stb_i,
   input  wire logic        wb_cyc_i,
   output logic [31:0]      wb_dat_o,
   output logic             wb_ack_o,
   output logic             int_o
);

   logic                   start;
   logic                   busy;
   logic                   done_pulse;
   logic                   clr;
   logic                   store_clr;
   logic                   feed_en;
   logic                   feed_last;
   logic                   store_last;
   logic [`FIR_ADDR_W-1:0] feed_idx;
   logic [`FIR_ADDR_W-1:0] store_idx;
   logic                   out_valid;
   fir_dsp_pkg::acc_t      out_acc;

   fir_buf_if #(.payload_t(fir_dsp_pkg::sample_t)) in_buf ();
   fir_buf_if #(.payload_t(fir_dsp_pkg::acc_t))    out_buf ();

   assign in_buf.rd_addr  = feed_idx;
   assign out_buf.wr_en   = out_valid;
   assign out_buf.wr_addr = store_idx;
   assign out_buf.wr_data = out_acc;

   fir_wb_regs u_wb_regs (
      .wb_clk_i     (wb_clk_i),
      .wb_rst_i     (wb_rst_i),
      .wb_adr_i     (wb_adr_i),
      .wb_dat_i     (wb_dat_i),
      .wb_we_i      (wb_we_i),
      .wb_stb_i     (wb_stb_i),
      .wb_cyc_i     (wb_cyc_i),
      .busy_i       (busy),
      .done_pulse_i (done_pulse),
      .wb_dat_o     (wb_dat_o),
      .wb_ack_o     (wb_ack_o),
      .start_o      (start),
      .int_o        (int_o),
      .in_wr_o      (in_buf),
      .out_rd_o     (out_buf)
   );

   fir_seq_fsm u_seq_fsm (
      .wb_clk_i     (wb_clk_i),
      .wb_rst_i     (wb_rst_i),
      .start_i      (start),
      .feed_last_i  (feed_last),
      .store_last_i (store_last),
      .out_valid_i  (out_valid),
      .busy_o       (busy),
      .clr_o        (clr),
      .feed_en_o    (feed_en),
      .store_clr_o  (store_clr),
      .done_pulse_o (done_pulse)
   );

   fir_sample_counter u_feed_cnt (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .clr_i    (clr),
      .en_i     (feed_en),
      .idx_o    (feed_idx),
      .last_o   (feed_last)
   );

   fir_sample_counter u_store_cnt (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .clr_i    (store_clr),
      .en_i     (out_valid),
      .idx_o    (store_idx),
      .last_o   (store_last)
   );

   fir_sample_buffer #(.payload_t(fir_dsp_pkg::sample_t)) u_in_buf (
      .wb_clk_i (wb_clk_i),
      .bus      (in_buf)
   );

   fir_sample_buffer #(.payload_t(fir_dsp_pkg::acc_t)) u_out_buf (
      .wb_clk_i (wb_clk_i),
      .bus      (out_buf)
   );

   fir_filter u_filter (
      .wb_clk_i    (wb_clk_i),
      .wb_rst_i    (wb_rst_i),
      .clr_i       (clr),
      .in_valid_i  (feed_en),
      .in_sample_i (in_buf.rd_data),
      .out_valid_o (out_valid),
      .out_acc_o   (out_acc)
   );

endmodule

`default_nettype wire

// File: fir_wb_regs.sv
`include "fir_config.svh"
`default_nettype none

module fir_wb_regs (
   input  wire logic                 wb_clk_i,
   input  wire logic                 wb_rst_i,
   input  wire fir_bus_pkg::wb_data_t wb_adr_i,
   input  wire fir_bus_pkg::wb_data_t wb_dat_i,
   input  wire logic                 wb_we_i,
   input  wire logic                 wb_stb_i,
   input  wire logic                 wb_cyc_i,
   input  wire logic                 busy_i,
   input  wire logic                 done_pulse_i,
   output fir_bus_pkg::wb_data_t     wb_dat_o,
   output logic                      wb_ack_o,
   output logic                      start_o,
   output logic                      int_o,
   fir_buf_if.writer                 in_wr_o,
   fir_buf_if.reader                 out_rd_o
);

   fir_bus_pkg::reg_idx_e  reg_idx;
   logic                   wr_stb;
   logic [`FIR_ADDR_W-1:0] wr_addr_q;
   logic [`FIR_ADDR_W-1:0] rd_addr_q;
   logic [15:0]            wr_data_q;
   logic                   irq_en_q;
   logic                   done_q;

   assign reg_idx  = fir_bus_pkg::reg_idx_e'(wb_adr_i[5:2]);
   assign wb_ack_o = wb_stb_i & wb_cyc_i;
   assign wr_stb   = wb_ack_o & wb_we_i;

   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         start_o   <= 1'b0;
         irq_en_q  <= 1'b0;
         wr_addr_q <= '0;
         rd_addr_q <= '0;
         wr_data_q <= '0;
         done_q    <= 1'b0;
      end else begin
         // one-cycle pulse, never held
         start_o <= wr_stb && reg_idx == fir_bus_pkg::REG_CTRL &&
                    wb_dat_i[fir_bus_pkg::CTRL_START_BIT];
         if (wr_stb) begin
            case (reg_idx)
               fir_bus_pkg::REG_CTRL:    irq_en_q  <= wb_dat_i[fir_bus_pkg::CTRL_IRQ_EN_BIT];
               fir_bus_pkg::REG_WR_ADDR: wr_addr_q <= wb_dat_i[`FIR_ADDR_W-1:0];
               fir_bus_pkg::REG_WR_DATA: wr_data_q <= wb_dat_i[15:0];
               fir_bus_pkg::REG_RD_ADDR: rd_addr_q <= wb_dat_i[`FIR_ADDR_W-1:0];
               default: ;
            endcase
         end
         // a finishing block wins over a late start
         if (done_pulse_i) begin
            done_q <= 1'b1;
         end else if (start_o) begin
            done_q <= 1'b0;
         end
      end
   end

   // input buffer is frozen while a block runs
   assign in_wr_o.wr_en   = wr_stb && reg_idx == fir_bus_pkg::REG_WR_DATA && !busy_i;
   assign in_wr_o.wr_addr = wr_addr_q;
   assign in_wr_o.wr_data = wb_dat_i[15:0];

   assign out_rd_o.rd_addr = rd_addr_q;

   assign int_o = done_q & irq_en_q;

   always_comb begin
      wb_dat_o = '0;
      case (reg_idx)
         fir_bus_pkg::REG_CTRL:    wb_dat_o[fir_bus_pkg::CTRL_IRQ_EN_BIT] = irq_en_q;
         fir_bus_pkg::REG_WR_ADDR: wb_dat_o[`FIR_ADDR_W-1:0] = wr_addr_q;
         fir_bus_pkg::REG_WR_DATA: wb_dat_o[15:0] = wr_data_q;
         fir_bus_pkg::REG_RD_ADDR: wb_dat_o[`FIR_ADDR_W-1:0] = rd_addr_q;
         fir_bus_pkg::REG_STATUS: begin
            wb_dat_o[fir_bus_pkg::STAT_BUSY_BIT] = busy_i;
            wb_dat_o[fir_bus_pkg::STAT_DONE_BIT] = done_q;
         end
         fir_bus_pkg::REG_RD_DATA: wb_dat_o = out_rd_o.rd_data;
         default: wb_dat_o = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
fir_bus_pkg.sv
fir_dsp_pkg.sv
fir_buf_if.sv
fir_wb_regs.sv
fir_seq_fsm.sv
fir_sample_counter.sv
fir_sample_buffer.sv
fir_filter.sv
fir_top.sv
fir_assertions.sv
tb_fir_top.sv

// File: tb_fir_top.sv
`include "fir_config.svh"
`default_nettype none

module tb_fir_top;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int ACK_LIMIT  = 16;
   localparam int POLL_LIMIT = 200;

   logic                  wb_clk_i = 1'b0;
   logic                  wb_rst_i;
   fir_bus_pkg::wb_data_t wb_adr_i;
   fir_bus_pkg::wb_data_t wb_dat_i;
   logic [3:0]            wb_sel_i;
   logic                  wb_we_i;
   logic                  wb_stb_i;
   logic                  wb_cyc_i;
   fir_bus_pkg::wb_data_t wb_dat_o;
   logic                  wb_ack_o;
   logic                  int_o;

   fir_dsp_pkg::sample_t blk [`FIR_BUF_DEPTH];
   fir_dsp_pkg::acc_t    expect_q [`FIR_BUF_DEPTH];
   int unsigned          cycle = 0;
   int                   errors = 0;
   int                   tests_run = 0;
   int                   tests_failed = 0;
   int                   test_start_errors = 0;

   fir_top u_fir_top (.*);

   always #5 wb_clk_i = ~wb_clk_i;

   always @(posedge wb_clk_i) begin
      cycle <= cycle + 1;
   end

   task automatic check_word(input string name, input fir_bus_pkg::wb_data_t got,
                             input fir_bus_pkg::wb_data_t exp);
      if (got !== exp) begin
         errors++;
         $display("FAILED %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic check_acc(input string name, input fir_dsp_pkg::acc_t got,
                            input fir_dsp_pkg::acc_t exp);
      if (got !== exp) begin
         errors++;
         $display("FAILED %s: got %h, expected %h", name, got, exp);
      end
   endtask

   // called 1 ns after a rising edge, returns 1 ns after the accepting edge
   task automatic wb_access(input logic we, input logic [3:0] idx,
                            input fir_bus_pkg::wb_data_t wdata,
                            output fir_bus_pkg::wb_data_t rdata);
      int n;
      wb_adr_i = {26'd0, idx, 2'b00};
      wb_dat_i = wdata;
      wb_we_i  = we;
      wb_stb_i = 1'b1;
      wb_cyc_i = 1'b1;
      n = 0;
      do begin
         @(negedge wb_clk_i);
         n++;
      end while (!wb_ack_o && n < ACK_LIMIT);
      rdata = wb_dat_o;
      if (!wb_ack_o) begin
         errors++;
         $display("no acknowledge from register %0d within %0d cycles", idx, n);
      end
      @(posedge wb_clk_i);
      #1;
      wb_stb_i = 1'b0;
      wb_cyc_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic wb_write(input logic [3:0] idx, input fir_bus_pkg::wb_data_t data);
      fir_bus_pkg::wb_data_t unused;
      wb_access(1'b1, idx, data, unused);
   endtask

   task automatic wb_read(input logic [3:0] idx, output fir_bus_pkg::wb_data_t data);
      wb_access(1'b0, idx, '0, data);
   endtask

   task automatic wait_status(input int bit_pos, input string what);
      fir_bus_pkg::wb_data_t st;
      int n;
      n = 0;
      do begin
         wb_read(fir_bus_pkg::REG_STATUS, st);
         n++;
      end while (st[bit_pos] !== 1'b1 && n < POLL_LIMIT);
      if (st[bit_pos] !== 1'b1) begin
         errors++;
         $display("%s never showed in STATUS within %0d polls", what, n);
      end
   endtask

   task automatic wait_done();
      wait_status(fir_bus_pkg::STAT_DONE_BIT, "done");
   endtask

   // busy seen means the start reached the FSM and done is already cleared
   task automatic start_block(input logic irq_en);
      wb_write(fir_bus_pkg::REG_CTRL, {30'd0, irq_en, 1'b1});
      wait_status(fir_bus_pkg::STAT_BUSY_BIT, "busy");
   endtask

   task automatic load_block();
      for (int i = 0; i < `FIR_BUF_DEPTH; i++) begin
         wb_write(fir_bus_pkg::REG_WR_ADDR, i);
         wb_write(fir_bus_pkg::REG_WR_DATA, {16'h0000, blk[i]});
      end
   endtask

   // direct convolution, zero history before index 0
   function automatic fir_dsp_pkg::acc_t model_out(input int n);
      fir_dsp_pkg::acc_t acc;
      acc = '0;
      for (int k = 0; k < `FIR_TAPS; k++) begin
         if (n - k >= 0) begin
            acc += fir_dsp_pkg::acc_t'(blk[n-k]) *
                   fir_dsp_pkg::acc_t'(fir_dsp_pkg::FIR_COEFS[k]);
         end
      end
      return acc;
   endfunction

   task automatic fill_model();
      for (int i = 0; i < `FIR_BUF_DEPTH; i++) begin
         expect_q[i] = model_out(i);
      end
   endtask

   task automatic check_block();
      fir_bus_pkg::wb_data_t rd;
      for (int i = 0; i < `FIR_BUF_DEPTH; i++) begin
         wb_write(fir_bus_pkg::REG_RD_ADDR, i);
         wb_read(fir_bus_pkg::REG_RD_DATA, rd);
         check_acc($sformatf("rd_data[%0d]", i), rd, expect_q[i]);
      end
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors == test_start_errors) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", name, errors - test_start_errors);
      end
      test_start_errors = errors;
   endtask

   task automatic test_reset_defaults();
      fir_bus_pkg::wb_data_t rd;
      check_word("int_o", {31'd0, int_o}, '0);
      wb_read(fir_bus_pkg::REG_STATUS, rd);
      check_word("status", rd, '0);
      wb_read(fir_bus_pkg::REG_CTRL, rd);
      check_word("ctrl", rd, '0);
      wb_read(4'd7, rd);
      check_word("reg 7", rd, '0);
      wb_read(4'd15, rd);
      check_word("reg 15", rd, '0);
      end_test("reset_defaults");
   endtask

   task automatic test_reg_readback();
      fir_bus_pkg::wb_data_t rd;
      wb_write(fir_bus_pkg::REG_WR_ADDR, 32'h13);
      wb_read(fir_bus_pkg::REG_WR_ADDR, rd);
      check_word("wr_addr", rd, 32'h13);
      wb_write(fir_bus_pkg::REG_WR_DATA, 32'h1234_beef);
      wb_read(fir_bus_pkg::REG_WR_DATA, rd);
      check_word("wr_data", rd, 32'h0000_beef);
      wb_write(fir_bus_pkg::REG_RD_ADDR, 32'h7);
      wb_read(fir_bus_pkg::REG_RD_ADDR, rd);
      check_word("rd_addr", rd, 32'h7);
      wb_write(fir_bus_pkg::REG_CTRL, 32'h2);
      wb_read(fir_bus_pkg::REG_CTRL, rd);
      check_word("ctrl", rd, 32'h2);
      // start bit must read back as 0
      wb_write(fir_bus_pkg::REG_CTRL, 32'h3);
      wb_read(fir_bus_pkg::REG_CTRL, rd);
      check_word("ctrl", rd, 32'h2);
      wait_done();
      wb_write(fir_bus_pkg::REG_CTRL, 32'h0);
      end_test("reg_readback");
   endtask

   task automatic test_impulse();
      for (int i = 0; i < `FIR_BUF_DEPTH; i++) begin
         blk[i] = '0;
         expect_q[i] = '0;
         if (i < `FIR_TAPS) begin
            expect_q[i] = fir_dsp_pkg::acc_t'(fir_dsp_pkg::FIR_COEFS[i]);
         end
      end
      blk[0] = 16'sd1;
      load_block();
      start_block(1'b0);
      wait_done();
      check_block();
      for (int i = 0; i < `FIR_BUF_DEPTH; i++) begin
         blk[i] = '0;
         expect_q[i] = '0;
         if (i >= 20 && i < 20 + `FIR_TAPS) begin
            expect_q[i] = 32'sd100 * fir_dsp_pkg::acc_t'(fir_dsp_pkg::FIR_COEFS[i-20]);
         end
      end
      blk[20] = 16'sd100;
      load_block();
      start_block(1'b0);
      wait_done();
      check_block();
      end_test("impulse");
   endtask

   task automatic run_random_block(input string name);
      for (int i = 0; i < `FIR_BUF_DEPTH; i++) begin
         blk[i] = fir_dsp_pkg::sample_t'($urandom);
      end
      load_block();
      fill_model();
      start_block(1'b0);
      wait_done();
      // irq_en off so done alone leaves int_o low
      check_word("int_o", {31'd0, int_o}, '0);
      check_block();
      end_test(name);
   endtask

   task automatic test_done_irq();
      fir_bus_pkg::wb_data_t rd;
      int unsigned restart_cycle;
      // buffer still holds the random block
      start_block(1'b1);
      wb_write(fir_bus_pkg::REG_WR_ADDR, `FIR_BUF_DEPTH - 1);
      wb_write(fir_bus_pkg::REG_WR_DATA, 32'h7fff);
      wb_write(fir_bus_pkg::REG_CTRL, 32'h3);
      restart_cycle = cycle;
      wait_done();
      if (cycle >= restart_cycle + `FIR_BUF_DEPTH) begin
         errors++;
         $display("a start written while busy restarted the running block");
      end
      check_word("int_o", {31'd0, int_o}, 32'h1);
      wb_read(fir_bus_pkg::REG_STATUS, rd);
      check_word("status", rd, 32'h2);
      fill_model();
      check_block();
      start_block(1'b1);
      check_word("int_o", {31'd0, int_o}, '0);
      wb_read(fir_bus_pkg::REG_STATUS, rd);
      check_word("status", rd, 32'h1);
      wait_done();
      wb_write(fir_bus_pkg::REG_CTRL, 32'h0);
      end_test("done_irq");
   endtask

   initial begin
      void'($urandom(32'h7564));
      wb_rst_i = 1'b1;
      wb_adr_i = '0;
      wb_dat_i = '0;
      wb_sel_i = 4'hf;
      wb_we_i  = 1'b0;
      wb_stb_i = 1'b0;
      wb_cyc_i = 1'b0;
      repeat (2) @(posedge wb_clk_i);
      #1;
      wb_rst_i = 1'b0;

      test_reset_defaults();
      test_reg_readback();
      test_impulse();
      run_random_block("random_block");
      test_done_irq();
      run_random_block("back_to_back");

      $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
